/* source/cpu_pkg.sv */
// shared types and constants for the 6502-style core
// opcodes the decode ROM knows, timing states and reset values
package cpu_pkg;

    // opcodes with their own sequence; any other byte runs as a two-cycle nop
    typedef enum logic [7:0] {
        OP_BRK     = 8'h00,
        OP_STA_ZP  = 8'h85,
        OP_LDA_IMM = 8'hA9,
        OP_NOP     = 8'hEA
    } opcode_e;

    // timing control unit states
    typedef enum logic [2:0] {
        T0 = 3'd0,
        T1 = 3'd1,
        T2 = 3'd2,
        T3 = 3'd3,
        T4 = 3'd4,
        T5 = 3'd5,
        T6 = 3'd6,
        T7 = 3'd7
    } tcu_e;

    // reset joins the brk sequence at its first stack cycle
    localparam tcu_e TCU_RESET = T2;

    // stack pointer after reset, walks down to fe during the sequence
    localparam logic [7:0] S_RESET = 8'h00;

    // low byte of the reset vector, high byte follows at +1
    localparam logic [15:0] VECTOR_RESET = 16'hFFFC;

endpackage

/* source/decoder.sv */
// decode ROM of the core
// maps opcode and timing state to bus strobes and the next timing state
// purely combinational, one step per rising clock edge
`timescale 1ns/1ps

module decoder (
    input  logic [7:0]      i_ir,
    input  cpu_pkg::tcu_e   i_tcu,
    output cpu_pkg::tcu_e   o_tcu,
    output logic            o_rw,
    output logic            o_dl_db,
    output logic            o_dl_adh,
    output logic            o_dl_adl,
    output logic            o_i_pc,
    output logic            o_adl_pcl,
    output logic            o_adh_pch,
    output logic            o_pcl_adl,
    output logic            o_pch_adh,
    output logic            o_ac_db,
    output logic            o_s_adl,
    output logic            o_add_adl,
    output logic            o_add_sb,
    output logic            o_0_adl0,
    output logic            o_0_adl1,
    output logic            o_0_adh0,
    output logic            o_0_adh1_7,
    output logic            o_sb_db,
    output logic            o_sb_ac,
    output logic            o_sb_s,
    output logic            o_db_add,
    output logic            o_adl_add,
    output logic            o_0_add,
    output logic            o_sb_add,
    output logic            o_sums
);

    always_comb
    begin
        // step to the next timing state unless the sequence ends
        o_tcu = cpu_pkg::tcu_e'(i_tcu + 3'd1);

        o_rw       = 1'b1;
        o_dl_db    = 1'b0;
        o_dl_adh   = 1'b0;
        o_dl_adl   = 1'b0;
        o_i_pc     = 1'b0;
        o_adl_pcl  = 1'b0;
        o_adh_pch  = 1'b0;
        o_pcl_adl  = 1'b0;
        o_pch_adh  = 1'b0;
        o_ac_db    = 1'b0;
        o_s_adl    = 1'b0;
        o_add_adl  = 1'b0;
        o_add_sb   = 1'b0;
        o_0_adl0   = 1'b0;
        o_0_adl1   = 1'b0;
        o_0_adh0   = 1'b0;
        o_0_adh1_7 = 1'b0;
        o_sb_db    = 1'b0;
        o_sb_ac    = 1'b0;
        o_sb_s     = 1'b0;
        o_db_add   = 1'b0;
        o_adl_add  = 1'b0;
        o_0_add    = 1'b0;
        o_sb_add   = 1'b0;
        o_sums     = 1'b0;

        case (i_tcu)
            cpu_pkg::T0:
            begin
                // opcode fetch at pc
                o_pcl_adl = 1'b1;
                o_pch_adh = 1'b1;
                o_i_pc    = 1'b1;
            end
            cpu_pkg::T1:
            begin
                o_pcl_adl = 1'b1;
                o_pch_adh = 1'b1;
                case (i_ir)
                    cpu_pkg::OP_BRK:
                    begin
                        // dummy read, pc stays
                    end
                    cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_STA_ZP:
                    begin
                        // operand read
                        o_i_pc = 1'b1;
                    end
                    default:
                    begin
                        // nop and unknown opcodes end here
                        o_tcu = cpu_pkg::T0;
                    end
                endcase
            end
            cpu_pkg::T2:
            begin
                case (i_ir)
                    cpu_pkg::OP_LDA_IMM:
                    begin
                        // operand from the latch through db and sb into ac
                        o_dl_db   = 1'b1;
                        o_sb_db   = 1'b1;
                        o_sb_ac   = 1'b1;
                        o_pcl_adl = 1'b1;
                        o_pch_adh = 1'b1;
                        o_tcu     = cpu_pkg::T0;
                    end
                    cpu_pkg::OP_STA_ZP:
                    begin
                        // write ac to 00:operand
                        o_rw       = 1'b0;
                        o_ac_db    = 1'b1;
                        o_dl_adl   = 1'b1;
                        o_0_adh0   = 1'b1;
                        o_0_adh1_7 = 1'b1;
                        o_tcu      = cpu_pkg::T0;
                    end
                    cpu_pkg::OP_BRK:
                    begin
                        // read 01:s, floating sb adds ff so add = s - 1
                        o_s_adl    = 1'b1;
                        o_0_adh1_7 = 1'b1;
                        o_adl_add  = 1'b1;
                        o_sb_add   = 1'b1;
                        o_sums     = 1'b1;
                    end
                    default: o_tcu = cpu_pkg::T0;
                endcase
            end
            cpu_pkg::T3:
            begin
                case (i_ir)
                    cpu_pkg::OP_BRK:
                    begin
                        // read 01:add and decrement once more
                        o_add_adl  = 1'b1;
                        o_0_adh1_7 = 1'b1;
                        o_adl_add  = 1'b1;
                        o_sb_add   = 1'b1;
                        o_sums     = 1'b1;
                    end
                    default: o_tcu = cpu_pkg::T0;
                endcase
            end
            cpu_pkg::T4:
            begin
                case (i_ir)
                    cpu_pkg::OP_BRK:
                    begin
                        // last stack read, s takes add
                        o_add_adl  = 1'b1;
                        o_0_adh1_7 = 1'b1;
                        o_add_sb   = 1'b1;
                        o_sb_s     = 1'b1;
                    end
                    default: o_tcu = cpu_pkg::T0;
                endcase
            end
            cpu_pkg::T5:
            begin
                case (i_ir)
                    cpu_pkg::OP_BRK:
                    begin
                        // fffc, adh left precharged
                        o_0_adl0 = 1'b1;
                        o_0_adl1 = 1'b1;
                    end
                    default: o_tcu = cpu_pkg::T0;
                endcase
            end
            cpu_pkg::T6:
            begin
                case (i_ir)
                    cpu_pkg::OP_BRK:
                    begin
                        // read fffd, low vector byte from latch into add
                        o_0_adl1 = 1'b1;
                        o_dl_db  = 1'b1;
                        o_db_add = 1'b1;
                        o_0_add  = 1'b1;
                        o_sums   = 1'b1;
                    end
                    default: o_tcu = cpu_pkg::T0;
                endcase
            end
            cpu_pkg::T7:
            begin
                case (i_ir)
                    cpu_pkg::OP_BRK:
                    begin
                        // jump, address pins already show the vector
                        o_add_adl = 1'b1;
                        o_adl_pcl = 1'b1;
                        o_dl_adh  = 1'b1;
                        o_adh_pch = 1'b1;
                        o_tcu     = cpu_pkg::T0;
                    end
                    default: o_tcu = cpu_pkg::T0;
                endcase
            end
            default: o_tcu = cpu_pkg::T0;
        endcase
    end

endmodule

/* source/instruction_register.sv */
// instruction register and timing counter
// opcode is taken from the data pins at the end of t0
// reset enters the brk sequence
`timescale 1ns/1ps

module instruction_register (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic [7:0]      i_data,
    input  cpu_pkg::tcu_e   i_tcu_next,
    output logic [7:0]      o_ir,
    output cpu_pkg::tcu_e   o_tcu
);

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_ir  <= cpu_pkg::OP_BRK;
            o_tcu <= cpu_pkg::TCU_RESET;
        end
        else
        begin
            o_tcu <= i_tcu_next;
            // fetch cycle, pins carry the next opcode
            if (o_tcu == cpu_pkg::T0)
            begin
                o_ir <= i_data;
            end
        end
    end

endmodule

/* source/program_counter.sv */
// program counter, pcl and pch
// increments across both halves, bus loads win over the increment
`timescale 1ns/1ps

module program_counter (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_i_pc,
    input  logic        i_adl_pcl,
    input  logic        i_adh_pch,
    input  logic [7:0]  i_adl,
    input  logic [7:0]  i_adh,
    output logic [7:0]  o_pcl,
    output logic [7:0]  o_pch
);

    logic [15:0] pc_inc;

    // carry out of pcl goes into pch
    assign pc_inc = {o_pch, o_pcl} + {15'd0, i_i_pc};

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_pcl <= 8'h00;
            o_pch <= 8'h00;
        end
        else
        begin
            if (i_adl_pcl)
            begin
                o_pcl <= i_adl;
            end
            else
            begin
                o_pcl <= pc_inc[7:0];
            end

            if (i_adh_pch)
            begin
                o_pch <= i_adh;
            end
            else
            begin
                o_pch <= pc_inc[15:8];
            end
        end
    end

endmodule

/* source/datapath_registers.sv */
// accumulator, stack pointer and adder with its hold register
// ac and s load from sb, add holds the adder sum when sums is set
`timescale 1ns/1ps

module datapath_registers (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [7:0]  i_sb,
    input  logic [7:0]  i_db,
    input  logic [7:0]  i_adl,
    input  logic        i_sb_ac,
    input  logic        i_sb_s,
    input  logic        i_sb_add,
    input  logic        i_0_add,
    input  logic        i_db_add,
    input  logic        i_adl_add,
    input  logic        i_sums,
    output logic [7:0]  o_ac,
    output logic [7:0]  o_s,
    output logic [7:0]  o_add
);

    logic [7:0] a_in;
    logic [7:0] b_in;

    // adder inputs sit at ff when no strobe selects them
    assign a_in = i_0_add ? 8'h00 : (i_sb_add ? i_sb : 8'hff);
    assign b_in = i_db_add ? i_db : (i_adl_add ? i_adl : 8'hff);

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_s <= cpu_pkg::S_RESET;
        end
        else if (i_sb_s)
        begin
            o_s <= i_sb;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_sb_ac)
        begin
            o_ac <= i_sb;
        end
        // carry out dropped, no flags here
        if (i_sums)
        begin
            o_add <= a_in + b_in;
        end
    end

endmodule

/* source/bus_network.sv */
// data latch and the four precharged internal buses
// each bus idles at ff and every enabled source pulls bits low (wired and)
// also drives the address and data pins
`timescale 1ns/1ps

module bus_network (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [7:0]  i_data,
    input  logic        i_dl_db,
    input  logic        i_dl_adh,
    input  logic        i_dl_adl,
    input  logic        i_pcl_adl,
    input  logic        i_pch_adh,
    input  logic        i_ac_db,
    input  logic        i_s_adl,
    input  logic        i_add_adl,
    input  logic        i_add_sb,
    input  logic        i_0_adl0,
    input  logic        i_0_adl1,
    input  logic        i_0_adh0,
    input  logic        i_0_adh1_7,
    input  logic        i_sb_db,
    input  logic [7:0]  i_pcl,
    input  logic [7:0]  i_pch,
    input  logic [7:0]  i_ac,
    input  logic [7:0]  i_s,
    input  logic [7:0]  i_add,
    output logic [7:0]  o_db,
    output logic [7:0]  o_sb,
    output logic [7:0]  o_adl,
    output logic [7:0]  o_adh,
    output logic [15:0] o_addr,
    output logic [7:0]  o_data
);

    logic [7:0] dl;
    logic [7:0] db_pull;
    logic [7:0] sb_pull;

    // byte read in one cycle is available from the latch in the next
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            dl <= 8'h00;
        end
        else
        begin
            dl <= i_data;
        end
    end

    assign db_pull = (i_dl_db ? dl : 8'hff) & (i_ac_db ? i_ac : 8'hff);
    assign sb_pull = i_add_sb ? i_add : 8'hff;

    // sb_db shorts the two buses so both see every pull-down
    assign o_db = i_sb_db ? (db_pull & sb_pull) : db_pull;
    assign o_sb = i_sb_db ? (db_pull & sb_pull) : sb_pull;

    assign o_adl = (i_dl_adl ? dl : 8'hff)
                 & (i_pcl_adl ? i_pcl : 8'hff)
                 & (i_s_adl ? i_s : 8'hff)
                 & (i_add_adl ? i_add : 8'hff)
                 & {6'h3f, ~i_0_adl1, ~i_0_adl0};

    assign o_adh = (i_dl_adh ? dl : 8'hff)
                 & (i_pch_adh ? i_pch : 8'hff)
                 & {{7{~i_0_adh1_7}}, ~i_0_adh0};

    // pins follow the buses in the same cycle
    assign o_addr = {o_adh, o_adl};
    assign o_data = o_db;

endmodule

/* source/cpu_core.sv */
// top level of the 6502-style core
// connects decode ROM, instruction register, pc, datapath and buses
// memory answers in the same cycle, o_sync marks each opcode fetch
`timescale 1ns/1ps

module cpu_core (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [7:0]  i_data,
    output logic [15:0] o_addr,
    output logic [7:0]  o_data,
    output logic        o_rw,
    output logic        o_sync
);

    logic [7:0]    ir;
    cpu_pkg::tcu_e tcu;
    cpu_pkg::tcu_e tcu_next;

    logic dl_db, dl_adh, dl_adl;
    logic i_pc, adl_pcl, adh_pch, pcl_adl, pch_adh;
    logic ac_db, s_adl, add_adl, add_sb;
    logic zero_adl0, zero_adl1, zero_adh0, zero_adh1_7;
    logic sb_db, sb_ac, sb_s;
    logic db_add, adl_add, zero_add, sb_add, sums;

    logic [7:0] pcl, pch, ac, s, add;
    logic [7:0] db, sb, adl, adh;

    assign o_sync = (tcu == cpu_pkg::T0);

    decoder u_decoder (
        .i_ir(ir), .i_tcu(tcu), .o_tcu(tcu_next), .o_rw(o_rw),
        .o_dl_db(dl_db), .o_dl_adh(dl_adh), .o_dl_adl(dl_adl),
        .o_i_pc(i_pc), .o_adl_pcl(adl_pcl), .o_adh_pch(adh_pch),
        .o_pcl_adl(pcl_adl), .o_pch_adh(pch_adh),
        .o_ac_db(ac_db), .o_s_adl(s_adl), .o_add_adl(add_adl), .o_add_sb(add_sb),
        .o_0_adl0(zero_adl0), .o_0_adl1(zero_adl1),
        .o_0_adh0(zero_adh0), .o_0_adh1_7(zero_adh1_7),
        .o_sb_db(sb_db), .o_sb_ac(sb_ac), .o_sb_s(sb_s),
        .o_db_add(db_add), .o_adl_add(adl_add), .o_0_add(zero_add),
        .o_sb_add(sb_add), .o_sums(sums)
    );

    instruction_register u_instruction_register (
        .i_clk(i_clk), .i_rst(i_rst), .i_data(i_data),
        .i_tcu_next(tcu_next), .o_ir(ir), .o_tcu(tcu)
    );

    program_counter u_program_counter (
        .i_clk(i_clk), .i_rst(i_rst), .i_i_pc(i_pc),
        .i_adl_pcl(adl_pcl), .i_adh_pch(adh_pch),
        .i_adl(adl), .i_adh(adh), .o_pcl(pcl), .o_pch(pch)
    );

    datapath_registers u_datapath_registers (
        .i_clk(i_clk), .i_rst(i_rst), .i_sb(sb), .i_db(db), .i_adl(adl),
        .i_sb_ac(sb_ac), .i_sb_s(sb_s), .i_sb_add(sb_add), .i_0_add(zero_add),
        .i_db_add(db_add), .i_adl_add(adl_add), .i_sums(sums),
        .o_ac(ac), .o_s(s), .o_add(add)
    );

    bus_network u_bus_network (
        .i_clk(i_clk), .i_rst(i_rst), .i_data(i_data),
        .i_dl_db(dl_db), .i_dl_adh(dl_adh), .i_dl_adl(dl_adl),
        .i_pcl_adl(pcl_adl), .i_pch_adh(pch_adh),
        .i_ac_db(ac_db), .i_s_adl(s_adl), .i_add_adl(add_adl), .i_add_sb(add_sb),
        .i_0_adl0(zero_adl0), .i_0_adl1(zero_adl1),
        .i_0_adh0(zero_adh0), .i_0_adh1_7(zero_adh1_7), .i_sb_db(sb_db),
        .i_pcl(pcl), .i_pch(pch), .i_ac(ac), .i_s(s), .i_add(add),
        .o_db(db), .o_sb(sb), .o_adl(adl), .o_adh(adh),
        .o_addr(o_addr), .o_data(o_data)
    );

endmodule

/* bench/cpu_core_assertions.sv */
// concurrent checks on the pins of cpu_core
// bound to every cpu_core instance from the testbench
`timescale 1ns/1ps

module cpu_core_assertions (
    input logic i_clk,
    input logic i_rst,
    input logic o_rw,
    input logic o_sync
);

    // opcode fetch is always a read
    no_write_on_fetch: assert property (
        @(posedge i_clk) disable iff (i_rst) !(o_sync && !o_rw)
    ) else $error("o_rw low during an opcode fetch");

    // writes last a single cycle
    single_cycle_write: assert property (
        @(posedge i_clk) disable iff (i_rst) !o_rw |=> o_rw
    ) else $error("o_rw held low for more than one cycle");

    // reset sequence ends in a fetch
    sync_after_reset: assert property (
        @(posedge i_clk) disable iff (i_rst) $fell(i_rst) |-> ##[1:8] o_sync
    ) else $error("no opcode fetch within eight cycles after reset");

endmodule

/* bench/tb_cpu_core.sv */
// testbench for the 6502-style core
// runs a directed program and an LFSR-built random program from the reset vector
// each cycle is compared against a reference trace model at the falling clock edge
`timescale 1ns/1ps

module tb_cpu_core;

    localparam int CLK_HALF = 50;
    localparam int WAIT_LIMIT = 12;
    localparam int RANDOM_COUNT = 150;
    localparam logic [15:0] PROG_BASE = 16'h8000;

    logic        clk;
    logic        i_rst;
    logic [7:0]  rd_data;
    logic [15:0] o_addr;
    logic [7:0]  o_data;
    logic        o_rw;
    logic        o_sync;

    logic [7:0]  mem [0:65535];
    logic [31:0] lfsr_state;
    logic        checking;
    logic        in_reset;
    int          error_count;

    // reference model state
    logic [2:0]  ref_t;
    logic [7:0]  ref_ir;
    logic [15:0] ref_pc;
    logic [7:0]  ref_ac;
    logic [7:0]  ref_s;
    logic [7:0]  ref_tmp;
    logic [7:0]  ref_opnd;
    logic [7:0]  ref_vlo;

    // memory answers within the same cycle
    assign rd_data = mem[o_addr];

    cpu_core i_dut (
        .i_clk(clk), .i_rst(i_rst), .i_data(rd_data),
        .o_addr(o_addr), .o_data(o_data), .o_rw(o_rw), .o_sync(o_sync)
    );

    bind cpu_core cpu_core_assertions u_assertions (
        .i_clk(i_clk), .i_rst(i_rst), .o_rw(o_rw), .o_sync(o_sync)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        string line;
        if (got !== exp)
        begin
            error_count++;
            line = $sformatf("[FAIL] %0t %s: got %0h expected %0h", $time, what, got, exp);
            fail_stop(line);
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = 32'd0;
        for (int k = 0; k < n; k++)
        begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic void ref_reset();
        ref_t = cpu_pkg::TCU_RESET;
        ref_ir = cpu_pkg::OP_BRK;
        ref_s = cpu_pkg::S_RESET;
    endfunction

    // expected {sync, address, rw, write data} of the current cycle before the model steps
    function automatic logic [25:0] ref_cycle();
        logic        sync;
        logic [15:0] a;
        logic        w;
        logic [7:0]  d;
        sync = (ref_t == 3'd0);
        a = ref_pc;
        w = 1'b1;
        d = 8'h00;
        case (ref_t)
            3'd0:
            begin
                ref_ir = mem[ref_pc];
                ref_pc = ref_pc + 16'd1;
                ref_t = 3'd1;
            end
            3'd1:
            begin
                if (ref_ir == cpu_pkg::OP_LDA_IMM || ref_ir == cpu_pkg::OP_STA_ZP)
                begin
                    ref_opnd = mem[ref_pc];
                    ref_pc = ref_pc + 16'd1;
                    ref_t = 3'd2;
                end
                else if (ref_ir == cpu_pkg::OP_BRK)
                    ref_t = 3'd2;
                else
                    ref_t = 3'd0;
            end
            3'd2:
            begin
                if (ref_ir == cpu_pkg::OP_LDA_IMM)
                begin
                    ref_ac = ref_opnd;
                    ref_t = 3'd0;
                end
                else if (ref_ir == cpu_pkg::OP_STA_ZP)
                begin
                    a = {8'h00, ref_opnd};
                    w = 1'b0;
                    d = ref_ac;
                    ref_t = 3'd0;
                end
                else
                begin
                    a = {8'h01, ref_s};
                    ref_tmp = ref_s - 8'd1;
                    ref_t = 3'd3;
                end
            end
            3'd3:
            begin
                a = {8'h01, ref_tmp};
                ref_tmp = ref_tmp - 8'd1;
                ref_t = 3'd4;
            end
            3'd4:
            begin
                a = {8'h01, ref_tmp};
                ref_s = ref_tmp;
                ref_t = 3'd5;
            end
            3'd5:
            begin
                a = cpu_pkg::VECTOR_RESET;
                ref_t = 3'd6;
            end
            3'd6:
            begin
                a = cpu_pkg::VECTOR_RESET + 16'd1;
                ref_vlo = mem[cpu_pkg::VECTOR_RESET];
                ref_t = 3'd7;
            end
            default:
            begin
                a = {mem[cpu_pkg::VECTOR_RESET + 16'd1], ref_vlo};
                ref_pc = a;
                ref_t = 3'd0;
            end
        endcase
        return {sync, a, w, d};
    endfunction

    // comparator and memory write port at mid-cycle where pins are stable
    always @(negedge clk)
    begin : compare_cycle
        logic [25:0] exp;
        if (checking)
        begin
            exp = ref_cycle();
            check_equal(32'(o_sync), 32'(exp[25]), "sync");
            check_equal(32'(o_addr), 32'(exp[24:9]), "address");
            check_equal(32'(o_rw), 32'(exp[8]), "rw");
            if (!exp[8])
                check_equal(32'(o_data), 32'(exp[7:0]), "write data");
        end
        else if (in_reset)
        begin
            check_equal(32'(o_rw), 32'd1, "rw during reset");
        end
        if (o_rw === 1'b0)
            mem[o_addr] = o_data;
    end

    task automatic apply_reset();
        @(posedge clk);
        i_rst <= 1'b1;
        @(posedge clk);
        checking = 1'b0;
        in_reset = 1'b1;
        repeat (9) @(posedge clk);
        i_rst <= 1'b0;
        ref_reset();
        checking = 1'b1;
        in_reset = 1'b0;
    endtask

    // returns at the falling edge of the next opcode fetch cycle
    task automatic wait_sync();
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
                fail_stop("timeout: no opcode fetch seen on o_sync");
        end
        while (o_sync !== 1'b1);
    endtask

    task automatic build_program();
        logic [15:0] p;
        logic [31:0] r;
        logic [7:0]  op;
        logic [7:0]  directed [0:9];
        directed = '{8'hA9, 8'h5A, 8'h85, 8'h40, 8'hEA, 8'h02, 8'hA9, 8'hC3, 8'h85, 8'h41};
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'(i[15:8] ^ {i[6:0], i[7]} ^ 8'h3c);
        mem[cpu_pkg::VECTOR_RESET] = PROG_BASE[7:0];
        mem[cpu_pkg::VECTOR_RESET + 16'd1] = PROG_BASE[15:8];
        p = PROG_BASE;
        for (int i = 0; i < 10; i++)
        begin
            mem[p] = directed[i];
            p = p + 16'd1;
        end
        for (int i = 0; i < RANDOM_COUNT; i++)
        begin
            r = lfsr_bits(2);
            if (r[1:0] == 2'd0)
                op = cpu_pkg::OP_LDA_IMM;
            else if (r[1:0] == 2'd1)
                op = cpu_pkg::OP_STA_ZP;
            else if (r[1:0] == 2'd2)
                op = cpu_pkg::OP_NOP;
            else
            begin
                // unknown opcode other than brk so the program stays linear
                do
                begin
                    r = lfsr_bits(8);
                    op = r[7:0];
                end
                while (op == 8'h00 || op == 8'h85 || op == 8'hA9 || op == 8'hEA);
            end
            mem[p] = op;
            p = p + 16'd1;
            if (op == cpu_pkg::OP_LDA_IMM || op == cpu_pkg::OP_STA_ZP)
            begin
                r = lfsr_bits(8);
                mem[p] = r[7:0];
                p = p + 16'd1;
            end
        end
    endtask

    initial
    begin : main
        logic [15:0] fetch_addr [0:6];
        fetch_addr = '{16'h8000, 16'h8002, 16'h8004, 16'h8005, 16'h8006, 16'h8008, 16'h800A};
        i_rst = 1'b1;
        checking = 1'b0;
        in_reset = 1'b0;
        error_count = 0;
        lfsr_state = 32'hfee4_3900;
        build_program();

        apply_reset();
        // directed fetch addresses follow the instruction lengths
        for (int i = 0; i < 7; i++)
        begin
            wait_sync();
            check_equal(32'(o_addr), 32'(fetch_addr[i]), "fetch address");
        end
        check_equal(32'(mem[16'h0040]), 32'h5A, "stored byte at 0040");
        check_equal(32'(mem[16'h0041]), 32'hC3, "stored byte at 0041");

        // random part checked on every cycle by the comparator
        // its first fetch was the last one of the directed part
        for (int i = 1; i < RANDOM_COUNT; i++)
            wait_sync();

        // restart, then cut the store to 0040 between operand read and write
        apply_reset();
        repeat (2) wait_sync();
        check_equal(32'(o_addr), 32'(PROG_BASE + 16'd2), "fetch of the store to 0040");
        mem[16'h0040] = 8'h00;
        apply_reset();
        wait_sync();
        check_equal(32'(o_addr), 32'(PROG_BASE), "fetch after second reset");
        check_equal(32'(mem[16'h0040]), 32'h00, "byte at 0040 after interrupted store");
        repeat (3) wait_sync();
        check_equal(32'(mem[16'h0040]), 32'h5A, "stored byte after second reset");

        if (error_count == 0)
        begin
            $display(">>> PASS");
            $finish;
        end
        else
        begin
            fail_stop("checks failed");
        end
    end

    initial
    begin
        #1_000_000;
        fail_stop("watchdog expired before the test completed");
    end

endmodule

/* verilog.f */
source/cpu_pkg.sv
source/decoder.sv
source/instruction_register.sv
source/program_counter.sv
source/datapath_registers.sv
source/bus_network.sv
source/cpu_core.sv
bench/cpu_core_assertions.sv
bench/tb_cpu_core.sv

/* run.sh */
#!/bin/sh
# compile and run the cpu_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_cpu_core -o sim_cpu_core
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed"
    exit $status
fi

./obj_dir/sim_cpu_core
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0
